// File: hdl/rename_pkg.sv
package rename_pkg;

  ////////////////////////////////////////////////////////////
  // Rename group
  ////////////////////////////////////////////////////////////

  // Micro-ops renamed per cycle, slot 0 is the oldest
  localparam int rename_width = 2;

  ////////////////////////////////////////////////////////////
  // Architectural register space
  ////////////////////////////////////////////////////////////

  localparam int arch_reg_count = 32;

  // Index into the architectural register file
  localparam int arch_index_size = 5;

  ////////////////////////////////////////////////////////////
  // Physical register file
  ////////////////////////////////////////////////////////////

  // Register 0 is hardwired zero and never handed out
  localparam int prf_size = 64;

  localparam int prf_index_size = 6;

  // Wide enough to hold prf_size itself
  localparam int prf_count_size = 7;

endpackage

// File: hdl/free_list.sv
`timescale 1ns/10ps

module free_list (
  input  logic                                                                 clock,
  input  logic                                                                 reset,
  input  logic                                                                 alloc_fire,
  input  logic                                                                 recover,
  input  logic [rename_pkg::prf_size-1:0]                                      recover_busy,
  input  logic                                                                 release_valid,
  input  logic [rename_pkg::prf_index_size-1:0]                                release_preg,
  input  logic [rename_pkg::rename_width-1:0]                                  alloc_req,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0] alloc_preg,
  output logic                                                                 allocatable
);

  import rename_pkg::*;

  // Set while a register is mapped or still in flight
  logic [prf_size-1:0]       busy;
  logic [prf_count_size-1:0] free_count;

  logic [prf_size-1:0]       busy_next;
  logic [prf_count_size-1:0] free_count_next;
  logic [prf_size-1:0]       pick_mask;
  logic [prf_count_size-1:0] req_count;
  logic [prf_count_size-1:0] recover_free_count;
  logic                      found;

  ////////////////////////////////////////////////////////////
  // Request count and group admission
  ////////////////////////////////////////////////////////////

  always_comb begin
    req_count = '0;
    for (int s = 0; s < rename_width; s++) begin
      if (alloc_req[s]) begin
        req_count = req_count + 1'b1;
      end
    end
  end

  // All or nothing
  assign allocatable = (req_count <= free_count);

  ////////////////////////////////////////////////////////////
  // Lowest-free pick, in slot order
  ////////////////////////////////////////////////////////////

  always_comb begin
    pick_mask = ~busy;
    found     = 1'b0;
    for (int s = 0; s < rename_width; s++) begin
      alloc_preg[s] = '0;
      found         = 1'b0;
      if (alloc_req[s]) begin
        for (int p = 0; p < prf_size; p++) begin
          if (!found && pick_mask[p]) begin
            alloc_preg[s] = prf_index_size'(p);
            pick_mask[p]  = 1'b0;
            found         = 1'b1;
          end
        end
      end
    end
  end

  // Next busy vector and count
  always_comb begin
    busy_next       = busy;
    free_count_next = free_count;
    // Commit-side release is never held off by a stall
    if (release_valid) begin
      busy_next[release_preg] = 1'b0;
      free_count_next         = free_count_next + 1'b1;
    end
    if (alloc_fire) begin
      for (int s = 0; s < rename_width; s++) begin
        if (alloc_req[s]) begin
          busy_next[alloc_preg[s]] = 1'b1;
        end
      end
      free_count_next = free_count_next - req_count;
    end
  end

  // Free registers in the committed image
  always_comb begin
    recover_free_count = '0;
    for (int p = 0; p < prf_size; p++) begin
      if (!recover_busy[p]) begin
        recover_free_count = recover_free_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= prf_size'(1);
      free_count <= prf_count_size'(prf_size - 1);
    end else if (recover) begin
      busy       <= recover_busy;
      free_count <= recover_free_count;
    end else begin
      busy       <= busy_next;
      free_count <= free_count_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  zero_reg_held: assert property (@(posedge clock) disable iff (reset) busy[0])
    else $error("physical register 0 marked free");

  release_of_busy: assert property (@(posedge clock) disable iff (reset)
    release_valid |-> busy[release_preg])
    else $error("released register %0d was already free", release_preg);

endmodule

// File: hdl/rename_map_table.sv
`timescale 1ns/10ps

module rename_map_table (
  input  logic                                                                   clock,
  input  logic                                                                   reset,
  input  logic                                                                   stall,
  input  logic                                                                   recover,
  input  logic [rename_pkg::arch_reg_count-1:0][rename_pkg::prf_index_size-1:0] recover_map,
  input  logic [rename_pkg::rename_width-1:0]                                    rename_valid,
  input  logic [rename_pkg::rename_width-1:0][rename_pkg::arch_index_size-1:0]  src1_arch,
  input  logic [rename_pkg::rename_width-1:0][rename_pkg::arch_index_size-1:0]  src2_arch,
  input  logic [rename_pkg::rename_width-1:0][rename_pkg::arch_index_size-1:0]  dest_arch,
  input  logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]   alloc_preg,
  input  logic                                                                   allocatable,
  output logic [rename_pkg::rename_width-1:0]                                    alloc_req,
  output logic                                                                   alloc_fire,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]   src1_preg,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]   src2_preg,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]   dest_preg,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]   old_preg
);

  import rename_pkg::*;

  // Speculative map, entry 0 is never written
  logic [prf_index_size-1:0] spec_map [arch_reg_count];

  // Destination 0 takes no register
  always_comb begin
    for (int s = 0; s < rename_width; s++) begin
      alloc_req[s] = rename_valid[s] && (dest_arch[s] != '0);
    end
  end

  assign alloc_fire = allocatable && !stall;

  ////////////////////////////////////////////////////////////
  // Lookup with bypass from older slots
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < rename_width; s++) begin
      src1_preg[s] = spec_map[src1_arch[s]];
      src2_preg[s] = spec_map[src2_arch[s]];
      old_preg[s]  = spec_map[dest_arch[s]];
      dest_preg[s] = alloc_req[s] ? alloc_preg[s] : '0;
      // Later older slot wins, so the newest write in the group is seen
      for (int j = 0; j < s; j++) begin
        if (alloc_req[j] && (dest_arch[j] == src1_arch[s])) begin
          src1_preg[s] = alloc_preg[j];
        end
        if (alloc_req[j] && (dest_arch[j] == src2_arch[s])) begin
          src2_preg[s] = alloc_preg[j];
        end
        if (alloc_req[j] && (dest_arch[j] == dest_arch[s])) begin
          old_preg[s] = alloc_preg[j];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Map update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < arch_reg_count; a++) begin
        spec_map[a] <= '0;
      end
    end else if (recover) begin
      // Rename inputs of this cycle are dropped
      for (int a = 0; a < arch_reg_count; a++) begin
        spec_map[a] <= recover_map[a];
      end
    end else if (alloc_fire) begin
      // Younger slot written last on a shared destination
      for (int s = 0; s < rename_width; s++) begin
        if (alloc_req[s]) begin
          spec_map[dest_arch[s]] <= alloc_preg[s];
        end
      end
    end
  end

endmodule

// File: hdl/committed_map_table.sv
`timescale 1ns/10ps

module committed_map_table (
  input  logic                                                                   clock,
  input  logic                                                                   reset,
  input  logic                                                                   recover,
  input  logic                                                                   commit_valid,
  input  logic [rename_pkg::arch_index_size-1:0]                                 commit_dest_arch,
  input  logic [rename_pkg::prf_index_size-1:0]                                  commit_preg,
  input  logic [rename_pkg::prf_index_size-1:0]                                  commit_old_preg,
  output logic                                                                   release_valid,
  output logic [rename_pkg::prf_index_size-1:0]                                  release_preg,
  output logic [rename_pkg::prf_size-1:0]                                        recover_busy,
  output logic [rename_pkg::arch_reg_count-1:0][rename_pkg::prf_index_size-1:0] recover_map
);

  import rename_pkg::*;

  // Retired state
  logic [prf_index_size-1:0] commit_map [arch_reg_count];
  logic [prf_size-1:0]       commit_busy;

  logic commit_write;

  // Zero destination never reaches the map
  assign commit_write = commit_valid && (commit_dest_arch != '0);

  // Old mapping goes back to the free list, except register 0
  assign release_valid = commit_valid && (commit_old_preg != '0);
  assign release_preg  = commit_old_preg;

  ////////////////////////////////////////////////////////////
  // Recovery image
  ////////////////////////////////////////////////////////////

  assign recover_busy = commit_busy;

  always_comb begin
    for (int a = 0; a < arch_reg_count; a++) begin
      recover_map[a] = commit_map[a];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < arch_reg_count; a++) begin
        commit_map[a] <= '0;
      end
      commit_busy <= prf_size'(1);
    end else begin
      if (commit_write) begin
        commit_map[commit_dest_arch] <= commit_preg;
      end
      if (release_valid) begin
        commit_busy[commit_old_preg] <= 1'b0;
      end
      // New mapping set after the clear
      if (commit_write) begin
        commit_busy[commit_preg] <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Recovery image must be stable on the recover edge
  no_commit_on_recover: assert property (@(posedge clock) disable iff (reset)
    recover |-> !commit_valid)
    else $error("commit arrived in a recover cycle");

endmodule

// File: hdl/rename_unit.sv
`timescale 1ns/10ps

module rename_unit (
  input  logic                                                                 clock,
  input  logic                                                                 reset,
  input  logic [rename_pkg::rename_width-1:0]                                  rename_valid,
  input  logic [rename_pkg::rename_width-1:0][rename_pkg::arch_index_size-1:0] src1_arch,
  input  logic [rename_pkg::rename_width-1:0][rename_pkg::arch_index_size-1:0] src2_arch,
  input  logic [rename_pkg::rename_width-1:0][rename_pkg::arch_index_size-1:0] dest_arch,
  input  logic                                                                 stall,
  input  logic                                                                 recover,
  output logic                                                                 ready,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]  src1_preg,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]  src2_preg,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]  dest_preg,
  output logic [rename_pkg::rename_width-1:0][rename_pkg::prf_index_size-1:0]  old_preg,
  input  logic                                                                 commit_valid,
  input  logic [rename_pkg::arch_index_size-1:0]                               commit_dest_arch,
  input  logic [rename_pkg::prf_index_size-1:0]                                commit_preg,
  input  logic [rename_pkg::prf_index_size-1:0]                                commit_old_preg
);

  import rename_pkg::*;

  // Map table to free list
  logic [rename_width-1:0]                      alloc_req;
  logic                                         alloc_fire;
  logic [rename_width-1:0][prf_index_size-1:0]  alloc_preg;

  // Committed side to both tables
  logic                                         release_valid;
  logic [prf_index_size-1:0]                    release_preg;
  logic [prf_size-1:0]                          recover_busy;
  logic [arch_reg_count-1:0][prf_index_size-1:0] recover_map;

  free_list free_list_inst (
    .clock         (clock),
    .reset         (reset),
    .alloc_fire    (alloc_fire),
    .recover       (recover),
    .recover_busy  (recover_busy),
    .release_valid (release_valid),
    .release_preg  (release_preg),
    .alloc_req     (alloc_req),
    .alloc_preg    (alloc_preg),
    .allocatable   (ready)
  );

  rename_map_table rename_map_table_inst (
    .clock        (clock),
    .reset        (reset),
    .stall        (stall),
    .recover      (recover),
    .recover_map  (recover_map),
    .rename_valid (rename_valid),
    .src1_arch    (src1_arch),
    .src2_arch    (src2_arch),
    .dest_arch    (dest_arch),
    .alloc_preg   (alloc_preg),
    .allocatable  (ready),
    .alloc_req    (alloc_req),
    .alloc_fire   (alloc_fire),
    .src1_preg    (src1_preg),
    .src2_preg    (src2_preg),
    .dest_preg    (dest_preg),
    .old_preg     (old_preg)
  );

  committed_map_table committed_map_table_inst (
    .clock            (clock),
    .reset            (reset),
    .recover          (recover),
    .commit_valid     (commit_valid),
    .commit_dest_arch (commit_dest_arch),
    .commit_preg      (commit_preg),
    .commit_old_preg  (commit_old_preg),
    .release_valid    (release_valid),
    .release_preg     (release_preg),
    .recover_busy     (recover_busy),
    .recover_map      (recover_map)
  );

endmodule

// File: verification/rename_unit_tasks.svh
  // LCG step with the upper bits as an architectural index
  function automatic logic [arch_index_size-1:0] random_arch();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[20:16];
  endfunction

  function automatic logic [arch_index_size-1:0] random_dest();
    logic [arch_index_size-1:0] r;
    r = random_arch();
    return (r == '0) ? arch_index_size'(1) : r;
  endfunction

  // Retires the oldest renamed micro-op
  task automatic commit_oldest();
    commit_valid     = 1'b1;
    commit_dest_arch = pend_dest.pop_front();
    commit_preg      = pend_new.pop_front();
    commit_old_preg  = pend_old.pop_front();
    @(posedge clock);
    retired_map[commit_dest_arch] = commit_preg;
    if (commit_old_preg != '0) begin
      retired_used[commit_old_preg] = 1'b0;
      used[commit_old_preg]         = 1'b0;
    end
    retired_used[commit_preg] = 1'b1;
    @(negedge clock);
    commit_valid = 1'b0;
  endtask

  // Pending group on the inputs must be dropped
  task automatic recover_pulse();
    recover      = 1'b1;
    rename_valid = '1;
    dest_arch    = {random_dest(), random_dest()};
    @(posedge clock);
    spec_map = retired_map;
    used     = retired_used;
    pend_dest.delete();
    pend_new.delete();
    pend_old.delete();
    @(negedge clock);
    recover      = 1'b0;
    rename_valid = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic fresh_alloc_test();
    rename_group(2'b11, '0, '0, {5'd2, 5'd1}, 1'b0);
    rename_group(2'b11, '0, '0, {5'd4, 5'd3}, 1'b0);
  endtask

  // Slot 1 reads and overwrites slot 0's destination
  task automatic bypass_test();
    rename_group(2'b11, {5'd7, 5'd1}, {5'd3, 5'd2}, {5'd7, 5'd7}, 1'b0);
    rename_group(2'b11, {5'd7, 5'd2}, {5'd1, 5'd0}, {5'd8, 5'd0}, 1'b0);
    rename_group(2'b01, {5'd0, 5'd7}, {5'd0, 5'd4}, {5'd0, 5'd9}, 1'b0);
  endtask

  task automatic stall_test();
    logic [rename_width-1:0][arch_index_size-1:0] d;
    d = {random_dest(), random_dest()};
    repeat (2) begin
      rename_group(2'b11, {5'd8, 5'd7}, {5'd1, 5'd2}, d, 1'b1);
    end
    rename_group(2'b11, {5'd8, 5'd7}, {5'd1, 5'd2}, d, 1'b0);
  endtask

  // Drain the free list so only groups without requests pass
  task automatic exhaust_test();
    while (free_count() > 0) begin
      rename_group(free_count() > 1 ? 2'b11 : 2'b01, {random_arch(), random_arch()},
                   {random_arch(), random_arch()}, {random_dest(), random_dest()}, 1'b0);
    end
    // Refused request on a destination that the next lookup reads
    rename_group(2'b01, '0, '0, {5'd0, 5'd7}, 1'b0);
    rename_group(2'b11, {5'd8, 5'd7}, {5'd2, 5'd1}, '0, 1'b0);
    rename_group(2'b00, {5'd8, 5'd7}, {5'd2, 5'd1}, {5'd3, 5'd3}, 1'b0);
    rename_group(2'b11, {5'd8, 5'd7}, {5'd2, 5'd1}, '0, 1'b0);
  endtask

  task automatic release_test();
    repeat (20) begin
      commit_oldest();
    end
    rename_group(2'b01, '0, '0, {5'd0, random_dest()}, 1'b0);
    rename_group(2'b11, '0, '0, {random_dest(), random_dest()}, 1'b0);
  endtask

  task automatic recover_test();
    for (int i = 0; i < 48; i++) begin
      if (pend_dest.size() > 0 && (random_arch() < 5'd14 || free_count() < 2)) begin
        commit_oldest();
      end else begin
        rename_group(2'b11, {random_arch(), random_arch()}, {random_arch(), random_arch()},
                     {random_arch(), random_arch()}, 1'b0);
      end
    end
    recover_pulse();
    // Four lookups per group over the whole map
    for (int a = 0; a < arch_reg_count; a += 4) begin
      rename_group(2'b11, {arch_index_size'(a + 1), arch_index_size'(a)},
                   {arch_index_size'(a + 3), arch_index_size'(a + 2)}, '0, 1'b0);
    end
    rename_group(2'b11, '0, '0, {random_dest(), random_dest()}, 1'b0);
  endtask

// File: verification/rename_unit_tb.sv
`timescale 1ns/10ps

module rename_unit_tb;

  import rename_pkg::*;

  // Cycles a group that fits may wait for ready
  localparam int ready_timeout = 8;

  logic                                         clock = 1'b0;
  logic                                         reset;
  logic [rename_width-1:0]                      rename_valid;
  logic [rename_width-1:0][arch_index_size-1:0] src1_arch;
  logic [rename_width-1:0][arch_index_size-1:0] src2_arch;
  logic [rename_width-1:0][arch_index_size-1:0] dest_arch;
  logic                                         stall;
  logic                                         recover;
  logic                                         ready;
  logic [rename_width-1:0][prf_index_size-1:0]  src1_preg;
  logic [rename_width-1:0][prf_index_size-1:0]  src2_preg;
  logic [rename_width-1:0][prf_index_size-1:0]  dest_preg;
  logic [rename_width-1:0][prf_index_size-1:0]  old_preg;
  logic                                         commit_valid;
  logic [arch_index_size-1:0]                   commit_dest_arch;
  logic [prf_index_size-1:0]                    commit_preg;
  logic [prf_index_size-1:0]                    commit_old_preg;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  logic [prf_index_size-1:0]  spec_map [arch_reg_count];
  logic [prf_index_size-1:0]  retired_map [arch_reg_count];
  logic                       used [prf_size];
  logic                       retired_used [prf_size];

  // Renamed but not yet committed, oldest first
  logic [arch_index_size-1:0] pend_dest [$];
  logic [prf_index_size-1:0]  pend_new [$];
  logic [prf_index_size-1:0]  pend_old [$];

  int unsigned lcg_state = 89;

  always #2 clock = ~clock;

  rename_unit rename_unit_inst (.*);

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_preg(string name, logic [prf_index_size-1:0] got,
                            logic [prf_index_size-1:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    assert (got === exp) else begin
      fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Lowest free register other than skip
  function automatic logic [prf_index_size-1:0] lowest_free(logic [prf_index_size-1:0] skip);
    for (int p = 1; p < prf_size; p++) begin
      if (!used[p] && prf_index_size'(p) != skip) begin
        return prf_index_size'(p);
      end
    end
    return '0;
  endfunction

  function automatic int free_count();
    int n;
    n = 0;
    for (int p = 0; p < prf_size; p++) begin
      if (!used[p]) begin
        n++;
      end
    end
    return n;
  endfunction

  // Mapping of arch seen by a slot, older slots of the group win over the map
  function automatic logic [prf_index_size-1:0] newest(
      input logic [arch_index_size-1:0]                   arch,
      input int                                           slot,
      input logic [rename_width-1:0][arch_index_size-1:0] d,
      input logic [rename_width-1:0][prf_index_size-1:0]  pick);
    logic [prf_index_size-1:0] p;
    p = spec_map[arch];
    for (int j = 0; j < slot; j++) begin
      if (pick[j] != '0 && d[j] == arch) begin
        p = pick[j];
      end
    end
    return p;
  endfunction

  task automatic rename_group(input logic [rename_width-1:0] valid,
                              input logic [rename_width-1:0][arch_index_size-1:0] s1,
                              input logic [rename_width-1:0][arch_index_size-1:0] s2,
                              input logic [rename_width-1:0][arch_index_size-1:0] d,
                              input logic hold);
    logic [rename_width-1:0][prf_index_size-1:0] pick;
    logic [rename_width-1:0][prf_index_size-1:0] eo;
    logic [prf_index_size-1:0]                   last;
    logic                                        fits;
    int                                          wants;
    int                                          waited;
    wants = 0;
    last  = '0;
    for (int s = 0; s < rename_width; s++) begin
      pick[s] = '0;
      if (valid[s] && d[s] != '0) begin
        pick[s] = lowest_free(last);
        last    = pick[s];
        wants++;
      end
    end
    fits         = (wants <= free_count());
    rename_valid = valid;
    src1_arch    = s1;
    src2_arch    = s2;
    dest_arch    = d;
    stall        = hold;
    #1;
    waited = 0;
    while (fits && ready !== 1'b1) begin
      if (waited == ready_timeout) begin
        fail_run("Timed out waiting for ready on a group that fits");
      end
      @(negedge clock);
      #1;
      waited++;
    end
    check_bit("ready", ready, fits);
    for (int s = 0; s < rename_width; s++) begin
      eo[s] = newest(d[s], s, d, pick);
      if (fits && valid[s]) begin
        check_preg($sformatf("src1_preg[%0d]", s), src1_preg[s], newest(s1[s], s, d, pick));
        check_preg($sformatf("src2_preg[%0d]", s), src2_preg[s], newest(s2[s], s, d, pick));
        check_preg($sformatf("dest_preg[%0d]", s), dest_preg[s], pick[s]);
        check_preg($sformatf("old_preg[%0d]", s), old_preg[s], eo[s]);
      end
    end
    @(posedge clock);
    // Slot order, so slot 1 wins on a shared destination
    for (int s = 0; s < rename_width; s++) begin
      if (fits && !hold && pick[s] != '0) begin
        used[pick[s]]  = 1'b1;
        spec_map[d[s]] = pick[s];
        pend_dest.push_back(d[s]);
        pend_new.push_back(pick[s]);
        pend_old.push_back(eo[s]);
      end
    end
    @(negedge clock);
    rename_valid = '0;
    stall        = 1'b0;
  endtask

  `include "rename_unit_tasks.svh"

  initial begin
    reset            = 1'b1;
    rename_valid     = '0;
    src1_arch        = '0;
    src2_arch        = '0;
    dest_arch        = '0;
    stall            = 1'b0;
    recover          = 1'b0;
    commit_valid     = 1'b0;
    commit_dest_arch = '0;
    commit_preg      = '0;
    commit_old_preg  = '0;
    for (int a = 0; a < arch_reg_count; a++) begin
      spec_map[a]    = '0;
      retired_map[a] = '0;
    end
    // Only register 0 is taken out of reset
    for (int p = 0; p < prf_size; p++) begin
      used[p]         = (p == 0);
      retired_used[p] = (p == 0);
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    fresh_alloc_test();
    bypass_test();
    stall_test();
    exhaust_test();
    release_test();
    recover_test();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+verification
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/rename_map_table.sv
hdl/committed_map_table.sv
hdl/rename_unit.sv
verification/rename_unit_tb.sv

// File: Makefile
SOURCES := $(wildcard hdl/*.sv verification/*.sv verification/*.svh)
BIN     := obj_dir/Vrename_unit_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): sim.f $(SOURCES)
	verilator --binary --timing --assert -f sim.f --top-module rename_unit_tb -Mdir obj_dir

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
